//--- mem_ss_defines.svh
// Memory subsystem shell constants
// Channel count, CSR geometry, register map and feature header fields

`ifndef MEM_SS_DEFINES_SVH
`define MEM_SS_DEFINES_SVH

// --------------------
// Geometry
`define NUM_MEM_CHANNELS 4
`define CSR_ADDR_W       11
`define CSR_DATA_W       64
`define SYNC_STAGES      3

// --------------------
// Device feature header fields
`define FEAT_ID          12'h00f
`define FEAT_VER         4'h1
`define NEXT_DFH_OFFSET  24'h1000
`define END_OF_LIST      1'b0
`define FEAT_TYPE        4'h3

// --------------------
// Register byte offsets, one 64-bit word each
`define REG_DFH          11'h000
`define REG_CAL_STATUS   11'h008
`define REG_RST_CTRL     11'h010
`define REG_SCRATCH      11'h018

`endif

//--- mem_ss_pkg.sv
// Memory subsystem shell types
// Vector types for channels and the CSR port, plus the reset handshake states

`default_nettype none

`include "mem_ss_defines.svh"

package mem_ss_pkg;

   // One bit per memory channel
   typedef logic [`NUM_MEM_CHANNELS-1:0] mem_chan_t;

   // CSR byte address and data word
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`CSR_DATA_W-1:0] csr_data_t;

   // Reset handshake toward the memory subsystem
   typedef enum logic [2:0] {
      RST_HS_START   = 3'd0,
      RST_HS_REQ     = 3'd1,
      RST_HS_COLD    = 3'd2,
      RST_HS_RELEASE = 3'd3,
      RST_HS_DONE    = 3'd4
   } rst_hs_state_t;

endpackage

`default_nettype wire

//--- cal_status_sync.sv
// Calibration status synchronizer
// Carries a vector of asynchronous level flags into the clk domain

`timescale 1ns/1ns
`default_nettype none

module cal_status_sync #(
   parameter int WIDTH  = 4,
   parameter int STAGES = 3
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [WIDTH-1:0] async_in,
   output logic [WIDTH-1:0] sync_out
);

   // Stage 0 is the metastability catcher, the last stage is the output
   logic [WIDTH-1:0] sync_chain [STAGES];

   always_ff @(posedge clk) begin
      if (reset) begin
         sync_chain <= '{default: '0};
      end else begin
         sync_chain[0] <= async_in;
         for (int i = 1; i < STAGES; i++) begin
            sync_chain[i] <= sync_chain[i-1];
         end
      end
   end

   assign sync_out = sync_chain[STAGES-1];

endmodule

`default_nettype wire

//--- mem_ss_rst_hs.sv
// Memory subsystem reset handshake
// Runs request, cold reset and release toward the subsystem after reset
// and again on a software request

`timescale 1ns/1ns
`default_nettype none

module mem_ss_rst_hs (
   input  logic clk,
   input  logic reset,
   input  logic soft_rst_req,
   input  logic ss_rst_rdy,
   input  logic ss_cold_rst_ack_n,
   output logic ss_rst_req,
   output logic ss_cold_rst_n,
   output logic rst_done,
   output logic rst_busy
);

   import mem_ss_pkg::*;

   rst_hs_state_t state;
   rst_hs_state_t state_next;

   // --------------------
   // Next state
   always_comb begin
      state_next = state;
      case (state)
         RST_HS_START: begin
            state_next = RST_HS_REQ;
         end
         RST_HS_REQ: begin
            // Wait for the subsystem to accept the request
            if (ss_rst_rdy) begin
               state_next = RST_HS_COLD;
            end
         end
         RST_HS_COLD: begin
            if (!ss_cold_rst_ack_n) begin
               state_next = RST_HS_RELEASE;
            end
         end
         RST_HS_RELEASE: begin
            if (ss_cold_rst_ack_n) begin
               state_next = RST_HS_DONE;
            end
         end
         RST_HS_DONE: begin
            // Software restart is only honoured once the last run finished
            if (soft_rst_req) begin
               state_next = RST_HS_REQ;
            end
         end
         default: begin
            state_next = RST_HS_START;
         end
      endcase
   end

   // --------------------
   // State and memory-side outputs
   // Outputs toward the subsystem come straight from flops so they never glitch
   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= RST_HS_START;
         ss_rst_req    <= 1'b0;
         ss_cold_rst_n <= 1'b1;
      end else begin
         state         <= state_next;
         ss_rst_req    <= (state_next == RST_HS_REQ);
         ss_cold_rst_n <= (state_next != RST_HS_COLD);
      end
   end

   // --------------------
   // Status toward the register block
   assign rst_done = (state == RST_HS_DONE);
   assign rst_busy = (state != RST_HS_DONE);

endmodule

`default_nettype wire

//--- mem_ss_csr.sv
// Memory subsystem register block
// Feature header, calibration status, reset control and scratch registers
// behind a single-cycle read and write strobe port

`timescale 1ns/1ns
`default_nettype none

`include "mem_ss_defines.svh"

module mem_ss_csr (
   input  logic                  clk,
   input  logic                  reset,
   input  mem_ss_pkg::csr_addr_t csr_addr,
   input  logic                  csr_wr,
   input  mem_ss_pkg::csr_data_t csr_wdata,
   input  logic                  csr_rd,
   output mem_ss_pkg::csr_data_t csr_rdata,
   output logic                  csr_rvalid,
   input  mem_ss_pkg::mem_chan_t cal_success,
   input  mem_ss_pkg::mem_chan_t cal_fail,
   input  logic                  rst_done,
   input  logic                  rst_busy,
   output logic                  soft_rst_req
);

   import mem_ss_pkg::*;

   // Fail flags start at bit 8 of the calibration status word
   localparam int CAL_FAIL_LSB = 8;

   csr_data_t dfh_value;
   csr_data_t cal_status_value;
   csr_data_t rst_ctrl_value;
   csr_data_t scratch;
   csr_data_t rd_mux;

   logic wr_rst_ctrl;
   logic wr_scratch;

   // --------------------
   // Read-only register contents

   // Feature header layout
   // type 63:60, reserved 59:41, eol 40, next 39:16, ver 15:12, id 11:0
   assign dfh_value = {
      `FEAT_TYPE,
      19'b0,
      `END_OF_LIST,
      `NEXT_DFH_OFFSET,
      `FEAT_VER,
      `FEAT_ID
   };

   always_comb begin
      cal_status_value = '0;
      cal_status_value[`NUM_MEM_CHANNELS-1:0]              = cal_success;
      cal_status_value[CAL_FAIL_LSB +: `NUM_MEM_CHANNELS] = cal_fail;
   end

   always_comb begin
      rst_ctrl_value    = '0;
      rst_ctrl_value[0] = rst_done;
      rst_ctrl_value[1] = rst_busy;
   end

   // --------------------
   // Write decode
   assign wr_rst_ctrl = csr_wr && (csr_addr == `REG_RST_CTRL);
   assign wr_scratch  = csr_wr && (csr_addr == `REG_SCRATCH);

   always_ff @(posedge clk) begin
      if (reset) begin
         scratch <= '0;
      end else if (wr_scratch) begin
         scratch <= csr_wdata;
      end
   end

   // One-cycle restart pulse, the handshake drops it unless it is idle in done
   always_ff @(posedge clk) begin
      if (reset) begin
         soft_rst_req <= 1'b0;
      end else begin
         soft_rst_req <= wr_rst_ctrl && csr_wdata[0];
      end
   end

   // --------------------
   // Read path
   always_comb begin
      case (csr_addr)
         `REG_DFH: begin
            rd_mux = dfh_value;
         end
         `REG_CAL_STATUS: begin
            rd_mux = cal_status_value;
         end
         `REG_RST_CTRL: begin
            rd_mux = rst_ctrl_value;
         end
         `REG_SCRATCH: begin
            rd_mux = scratch;
         end
         default: begin
            // Unmapped offsets read as zero
            rd_mux = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (csr_rd) begin
         csr_rdata <= rd_mux;
      end
   end

   // Valid follows the strobe by exactly one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_rd;
      end
   end

endmodule

`default_nettype wire

//--- mem_ss_top.sv
// Memory subsystem control and status shell
// Ties the calibration synchronizers, the reset handshake and the register block

`timescale 1ns/1ns
`default_nettype none

`include "mem_ss_defines.svh"

module mem_ss_top (
   input  logic                  clk,
   input  logic                  reset,

   // CSR port
   input  mem_ss_pkg::csr_addr_t csr_addr,
   input  logic                  csr_wr,
   input  mem_ss_pkg::csr_data_t csr_wdata,
   input  logic                  csr_rd,
   output mem_ss_pkg::csr_data_t csr_rdata,
   output logic                  csr_rvalid,

   // Asynchronous calibration levels from the memory subsystem
   input  mem_ss_pkg::mem_chan_t cal_success,
   input  mem_ss_pkg::mem_chan_t cal_fail,

   // Reset handshake toward the memory subsystem
   output logic                  ss_rst_req,
   output logic                  ss_cold_rst_n,
   input  logic                  ss_rst_rdy,
   input  logic                  ss_cold_rst_ack_n
);

   import mem_ss_pkg::*;

   mem_chan_t cal_success_sync;
   mem_chan_t cal_fail_sync;

   logic soft_rst_req;
   logic rst_done;
   logic rst_busy;

   // --------------------
   // Calibration status synchronizers
   cal_status_sync #(
      .WIDTH  (`NUM_MEM_CHANNELS),
      .STAGES (`SYNC_STAGES)
   ) u_cal_success_sync (
      .clk      (clk),
      .reset    (reset),
      .async_in (cal_success),
      .sync_out (cal_success_sync)
   );

   cal_status_sync #(
      .WIDTH  (`NUM_MEM_CHANNELS),
      .STAGES (`SYNC_STAGES)
   ) u_cal_fail_sync (
      .clk      (clk),
      .reset    (reset),
      .async_in (cal_fail),
      .sync_out (cal_fail_sync)
   );

   // --------------------
   // Reset handshake
   mem_ss_rst_hs u_rst_hs (
      .clk               (clk),
      .reset             (reset),
      .soft_rst_req      (soft_rst_req),
      .ss_rst_rdy        (ss_rst_rdy),
      .ss_cold_rst_ack_n (ss_cold_rst_ack_n),
      .ss_rst_req        (ss_rst_req),
      .ss_cold_rst_n     (ss_cold_rst_n),
      .rst_done          (rst_done),
      .rst_busy          (rst_busy)
   );

   // --------------------
   // Register block
   mem_ss_csr u_csr (
      .clk          (clk),
      .reset        (reset),
      .csr_addr     (csr_addr),
      .csr_wr       (csr_wr),
      .csr_wdata    (csr_wdata),
      .csr_rd       (csr_rd),
      .csr_rdata    (csr_rdata),
      .csr_rvalid   (csr_rvalid),
      .cal_success  (cal_success_sync),
      .cal_fail     (cal_fail_sync),
      .rst_done     (rst_done),
      .rst_busy     (rst_busy),
      .soft_rst_req (soft_rst_req)
   );

endmodule

`default_nettype wire

//--- tb_mem_ss_top.sv
// Memory subsystem shell testbench
// Runs operations from the test data file against the DUT and models the
// memory side of the reset handshake

`timescale 1ns/1ns
`default_nettype none

`include "mem_ss_defines.svh"

module tb_mem_ss_top;

   import mem_ss_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;

   logic      clk;
   logic      reset;
   csr_addr_t csr_addr;
   logic      csr_wr;
   csr_data_t csr_wdata;
   logic      csr_rd;
   csr_data_t csr_rdata;
   logic      csr_rvalid;
   mem_chan_t cal_success;
   mem_chan_t cal_fail;
   logic      ss_rst_req;
   logic      ss_cold_rst_n;
   logic      ss_rst_rdy;
   logic      ss_cold_rst_ack_n;

   int handshake_count;

   mem_ss_top dut (
      .clk               (clk),
      .reset             (reset),
      .csr_addr          (csr_addr),
      .csr_wr            (csr_wr),
      .csr_wdata         (csr_wdata),
      .csr_rd            (csr_rd),
      .csr_rdata         (csr_rdata),
      .csr_rvalid        (csr_rvalid),
      .cal_success       (cal_success),
      .cal_fail          (cal_fail),
      .ss_rst_req        (ss_rst_req),
      .ss_cold_rst_n     (ss_cold_rst_n),
      .ss_rst_rdy        (ss_rst_rdy),
      .ss_cold_rst_ack_n (ss_cold_rst_ack_n)
   );

   always #4 clk = ~clk;

   // Every rise of the request starts one handshake on the memory side
   always @(posedge ss_rst_req) begin
      handshake_count++;
   end

   // --------------------
   // Reporting
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input csr_data_t actual,
                              input csr_data_t expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                  $time, name, actual, expected);
         abort_run("value mismatch");
      end
   endtask

   // --------------------
   // CSR access
   // Every task starts and ends 1 ns after a rising edge
   task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
      csr_addr  = addr;
      csr_wdata = data;
      csr_wr    = 1'b1;
      @(posedge clk);
      #1;
      csr_wr = 1'b0;
   endtask

   task automatic read_csr(input csr_addr_t addr, output csr_data_t value);
      csr_addr = addr;
      csr_rd   = 1'b1;
      @(posedge clk);
      #1;
      csr_rd = 1'b0;
      // Valid rises right after the sampling edge and lasts one cycle
      check_value("csr_rvalid", 64'(csr_rvalid), 64'h1);
      value = csr_rdata;
      @(posedge clk);
      #1;
      check_value("csr_rvalid", 64'(csr_rvalid), 64'h0);
   endtask

   task automatic poll_rst_done(input csr_addr_t addr, output csr_data_t value);
      int cycles;
      cycles = 0;
      read_csr(addr, value);
      while (value[0] !== 1'b1) begin
         // Each read takes two cycles
         cycles += 2;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout: reset control never reported done");
         end
         read_csr(addr, value);
      end
   endtask

   // --------------------
   // Memory-side responder
   task automatic wait_random_cycles();
      int delay;
      delay = 1 + int'($urandom % 6);
      repeat (delay) begin
         @(posedge clk);
      end
      #1;
   endtask

   task automatic respond_handshake();
      int cycles;
      cycles = 0;
      while (ss_rst_req !== 1'b1) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout: DUT never raised the reset request");
         end
      end
      check_value("ss_cold_rst_n", 64'(ss_cold_rst_n), 64'h1);
      wait_random_cycles();
      ss_rst_rdy = 1'b1;
      cycles = 0;
      while (ss_cold_rst_n !== 1'b0) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout: DUT never asserted the cold reset");
         end
      end
      // Request drops on the same edge the cold reset goes low
      check_value("ss_rst_req", 64'(ss_rst_req), 64'h0);
      ss_rst_rdy = 1'b0;
      wait_random_cycles();
      ss_cold_rst_ack_n = 1'b0;
      cycles = 0;
      while (ss_cold_rst_n !== 1'b1) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout: DUT never released the cold reset");
         end
      end
      wait_random_cycles();
      ss_cold_rst_ack_n = 1'b1;
   endtask

   // --------------------
   // Test data operations
   task automatic set_calibration(input csr_addr_t addr, input csr_data_t data,
                                  input csr_data_t expected);
      csr_data_t value;
      cal_success = data[3:0];
      cal_fail    = data[11:8];
      repeat (5) begin
         @(posedge clk);
      end
      #1;
      read_csr(addr, value);
      check_value("cal_status", value, expected);
   endtask

   task automatic run_soft_reset(input csr_addr_t addr, input csr_data_t data,
                                 input csr_data_t expected);
      csr_data_t value;
      write_csr(addr, data);
      fork
         respond_handshake();
         begin
            // One idle cycle lets the restart pulse reach the FSM
            @(posedge clk);
            #1;
            read_csr(addr, value);
            // Busy set and done clear while the handshake runs
            check_value("rst_ctrl", value, 64'h2);
            poll_rst_done(addr, value);
            check_value("rst_ctrl", value, expected);
         end
      join
   endtask

   initial begin
      int        fd;
      int        fields;
      int        soft_resets;
      string     line;
      logic [3:0] op;
      csr_addr_t addr;
      csr_data_t data;
      csr_data_t expected;
      csr_data_t value;

      void'($urandom(32'h7e3bd700));
      clk               = 1'b0;
      reset             = 1'b1;
      csr_addr          = '0;
      csr_wr            = 1'b0;
      csr_wdata         = '0;
      csr_rd            = 1'b0;
      cal_success       = '0;
      cal_fail          = '0;
      ss_rst_rdy        = 1'b0;
      ss_cold_rst_ack_n = 1'b1;
      handshake_count   = 0;
      soft_resets       = 0;

      repeat (2) begin
         @(posedge clk);
      end
      #1;
      reset = 1'b0;
      check_value("ss_rst_req", 64'(ss_rst_req), 64'h0);
      check_value("ss_cold_rst_n", 64'(ss_cold_rst_n), 64'h1);
      check_value("csr_rvalid", 64'(csr_rvalid), 64'h0);

      // Power-on handshake
      fork
         respond_handshake();
         poll_rst_done(`REG_RST_CTRL, value);
      join
      check_value("rst_ctrl", value, 64'h1);

      // Scratch comes out of reset cleared
      read_csr(`REG_SCRATCH, value);
      check_value("scratch", value, 64'h0);

      fd = $fopen("mem_ss_testdata.txt", "r");
      if (fd == 0) begin
         abort_run("could not open the test data file");
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h", op, addr, data, expected);
            if (fields == 4) begin
               case (op)
                  4'h1: write_csr(addr, data);
                  4'h2: begin
                     read_csr(addr, value);
                     check_value("csr_rdata", value, expected);
                  end
                  4'h3: set_calibration(addr, data, expected);
                  4'h4: begin
                     run_soft_reset(addr, data, expected);
                     soft_resets++;
                  end
                  default: abort_run("unknown opcode in the test data file");
               endcase
            end
         end
      end
      $fclose(fd);

      check_value("handshake count", 64'(handshake_count), 64'(soft_resets + 1));
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_ss_testdata.txt
// Columns: opcode address data expected, all hex
// Opcodes: 1 write, 2 read and compare, 3 set calibration then read, 4 soft reset
2 000 0000000000000000 300000001000100f
2 010 0000000000000000 0000000000000001
1 018 0123456789abcdef 0000000000000000
2 018 0000000000000000 0123456789abcdef
1 018 fedcba9876543210 0000000000000000
2 018 0000000000000000 fedcba9876543210
1 000 ffffffffffffffff 0000000000000000
2 000 0000000000000000 300000001000100f
1 008 ffffffffffffffff 0000000000000000
2 008 0000000000000000 0000000000000000
2 020 0000000000000000 0000000000000000
1 020 000000000000dead 0000000000000000
2 020 0000000000000000 0000000000000000
2 7f8 0000000000000000 0000000000000000
3 008 0000000000000005 0000000000000005
3 008 0000000000000f0f 0000000000000f0f
3 008 0000000000000300 0000000000000300
3 008 0000000000000c03 0000000000000c03
2 018 0000000000000000 fedcba9876543210
4 010 0000000000000001 0000000000000001
2 018 0000000000000000 fedcba9876543210
3 008 0000000000000000 0000000000000000
4 010 0000000000000001 0000000000000001
1 010 0000000000000000 0000000000000000
2 010 0000000000000000 0000000000000001
2 000 0000000000000000 300000001000100f

//--- verilog.f
+incdir+.
mem_ss_pkg.sv
cal_status_sync.sv
mem_ss_rst_hs.sv
mem_ss_csr.sv
mem_ss_top.sv
tb_mem_ss_top.sv

//--- Makefile
# Verilator simulation of the memory subsystem shell

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -f verilog.f \
		--top-module tb_mem_ss_top -Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
